// File: riscvPkg.sv
package riscvPkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} aluOp_e;
    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_J, IMM_U} immSel_e;
    typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4, RES_IMM} resultSel_e;
    // zero encodings double as the bubble values
    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT} branchSel_e;
    typedef enum logic [1:0] {JMP_NONE, JMP_JAL, JMP_JALR} jumpSel_e;
    typedef enum logic [1:0] {FWD_REG, FWD_WB, FWD_ALUM, FWD_IMMM} fwdSel_e;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rView;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iView;
        // b-type shares this layout
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sView;
        // j-type shares this layout
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } uView;
    } instrWord_u;

    typedef struct packed {
        logic       regWrite;
        logic       memWrite;
        logic       aluSrc;
        aluOp_e     aluOp;
        immSel_e    immSel;
        resultSel_e resultSel;
        branchSel_e branch;
        jumpSel_e   jump;
    } ctrlSig_s;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] pcPlus4;
        instrWord_u  instr;
    } ifId_s;

    typedef struct packed {
        logic        regWrite;
        logic        memWrite;
        logic        aluSrc;
        aluOp_e      aluOp;
        resultSel_e  resultSel;
        branchSel_e  branch;
        jumpSel_e    jump;
        logic [31:0] pc;
        logic [31:0] pcPlus4;
        logic [31:0] rd1;
        logic [31:0] rd2;
        logic [31:0] extImm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
    } idEx_s;

    typedef struct packed {
        logic        regWrite;
        logic        memWrite;
        resultSel_e  resultSel;
        logic [31:0] aluResult;
        logic [31:0] writeData;
        logic [31:0] pcPlus4;
        logic [31:0] extImm;
        logic [4:0]  rd;
    } exMem_s;

    typedef struct packed {
        logic        regWrite;
        resultSel_e  resultSel;
        logic [31:0] aluResult;
        logic [31:0] readData;
        logic [31:0] pcPlus4;
        logic [31:0] extImm;
        logic [4:0]  rd;
    } memWb_s;

endpackage

// File: alu.sv
`timescale 1ns/100ps

module alu (
    input  riscvPkg::aluOp_e aluOp,
    input  logic [31:0]      a,
    input  logic [31:0]      b,
    output logic [31:0]      result,
    output logic             zero,
    output logic             neg
);
    import riscvPkg::*;

    // signed compare, shared by slt and blt
    assign neg = $signed(a) < $signed(b);

    always_comb begin
        case (aluOp)
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLT: result = {31'd0, neg};
            default: result = a + b;
        endcase
    end

    assign zero = (result == 32'd0);

endmodule

// File: regFile.sv
`timescale 1ns/100ps

module regFile (
    input  logic        clk,
    input  logic        we,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [32];

    // falling edge so decode sees writeback in the same cycle
    always_ff @(negedge clk) begin
        if (we && wa != 5'd0)
            regs[wa] <= wd;
    end

    // x0 reads zero
    assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

// File: hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit (
    input  logic              [4:0] rs1D,
    input  logic              [4:0] rs2D,
    input  logic              [4:0] rs1E,
    input  logic              [4:0] rs2E,
    input  logic              [4:0] rdE,
    input  logic              [4:0] rdM,
    input  logic              [4:0] rdW,
    input  logic                    regWriteM,
    input  logic                    regWriteW,
    input  logic                    loadE,
    input  logic                    immSelM,
    input  logic                    pcSrcE,
    output logic                    stallF,
    output logic                    stallD,
    output logic                    flushD,
    output logic                    flushE,
    output riscvPkg::fwdSel_e       forwardAE,
    output riscvPkg::fwdSel_e       forwardBE
);
    import riscvPkg::*;

    logic loadStall;

    // memory stage wins over writeback, lui forwards its immediate
    function automatic fwdSel_e pickFwd(input logic [4:0] rsE);
        if (rsE != 5'd0 && regWriteM && rsE == rdM)
            return immSelM ? FWD_IMMM : FWD_ALUM;
        else if (rsE != 5'd0 && regWriteW && rsE == rdW)
            return FWD_WB;
        else
            return FWD_REG;
    endfunction

    always_comb begin
        forwardAE = pickFwd(rs1E);
        forwardBE = pickFwd(rs2E);
    end

    // load result not ready until writeback
    assign loadStall = loadE && rdE != 5'd0 && (rdE == rs1D || rdE == rs2D);

    assign stallF = loadStall;
    assign stallD = loadStall;
    assign flushD = pcSrcE;
    assign flushE = loadStall || pcSrcE;

endmodule

// File: controlUnit.sv
`timescale 1ns/100ps

module controlUnit (
    input  riscvPkg::opcode_e  op,
    input  logic [2:0]         func3,
    input  logic               func7,
    output riscvPkg::ctrlSig_s ctrl
);
    import riscvPkg::*;

    aluOp_e     aluDec;
    branchSel_e brDec;

    // alu decoder, only add/sub differ by func7
    always_comb begin
        case (func3)
            3'b000:  aluDec = (op == OP && func7) ? ALU_SUB : ALU_ADD;
            3'b010:  aluDec = ALU_SLT;
            3'b110:  aluDec = ALU_OR;
            3'b111:  aluDec = ALU_AND;
            default: aluDec = ALU_ADD;
        endcase
    end

    always_comb begin
        case (func3)
            3'b000:  brDec = BR_EQ;
            3'b001:  brDec = BR_NE;
            3'b100:  brDec = BR_LT;
            default: brDec = BR_NONE;
        endcase
    end

    // main decoder
    always_comb begin
        ctrl = '0;
        case (op)
            OP: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluDec;
            end
            OP_IMM: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluDec;
            end
            LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.resultSel = RES_MEM;
            end
            STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSel   = IMM_S;
            end
            BRANCH: begin
                // compare by subtraction
                ctrl.aluOp  = ALU_SUB;
                ctrl.immSel = IMM_B;
                ctrl.branch = brDec;
            end
            JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSel    = IMM_J;
                ctrl.resultSel = RES_PC4;
                ctrl.jump      = JMP_JAL;
            end
            JALR: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.resultSel = RES_PC4;
                ctrl.jump      = JMP_JALR;
            end
            LUI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSel    = IMM_U;
                ctrl.resultSel = RES_IMM;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// File: riscvDatapath.sv
`timescale 1ns/100ps

module riscvDatapath #(
    parameter logic [31:0] resetPc = 32'h0
) (
    input  logic               clk,
    input  logic               rst,
    input  riscvPkg::ctrlSig_s ctrlD,
    output riscvPkg::opcode_e  op,
    output logic [2:0]         func3,
    output logic               func7,
    output logic [31:0]        imemAddr,
    input  logic [31:0]        imemData,
    output logic [31:0]        dmemAddr,
    output logic [31:0]        dmemWdata,
    output logic               dmemWe,
    input  logic [31:0]        dmemRdata
);
    import riscvPkg::*;

    ifId_s      ifId;
    idEx_s      idEx;
    exMem_s     exMem;
    memWb_s     memWb;
    instrWord_u instrD;

    logic [31:0] pcF, pcPlus4F, pcTargetE, rd1D, rd2D, extImmD, resultW;
    logic [31:0] srcAE, srcBE, writeDataE, aluResultE;
    logic [4:0]  rs1D, rs2D, rdD;
    logic        stallF, stallD, flushD, flushE, zeroE, negE, takenE, pcSrcE;
    fwdSel_e     forwardAE, forwardBE;

    function automatic logic [31:0] fwdMux(input fwdSel_e sel, input logic [31:0] regVal,
                                           input logic [31:0] wbVal, input logic [31:0] aluM,
                                           input logic [31:0] immM);
        case (sel)
            FWD_WB:   return wbVal;
            FWD_ALUM: return aluM;
            FWD_IMMM: return immM;
            default:  return regVal;
        endcase
    endfunction

    // fetch
    assign pcPlus4F = pcF + 32'd4;
    assign imemAddr = pcF;

    always_ff @(posedge clk) begin
        if (rst)
            pcF <= resetPc;
        else if (!stallF)
            pcF <= pcSrcE ? pcTargetE : pcPlus4F;
    end

    always_ff @(posedge clk) begin
        if (rst || flushD)
            ifId <= '0;
        else if (!stallD)
            ifId <= '{pc: pcF, pcPlus4: pcPlus4F, instr: imemData};
    end

    // decode
    assign instrD = ifId.instr;
    assign op     = opcode_e'(instrD.rView.opcode);
    assign func3  = instrD.rView.funct3;
    assign func7  = instrD.rView.funct7[5];
    assign rs1D   = instrD.rView.rs1;
    assign rs2D   = instrD.rView.rs2;
    assign rdD    = instrD.rView.rd;

    always_comb begin
        case (ctrlD.immSel)
            IMM_S: extImmD = {{20{instrD.sView.immHi[6]}}, instrD.sView.immHi,
                              instrD.sView.immLo};
            IMM_B: extImmD = {{20{instrD.sView.immHi[6]}}, instrD.sView.immLo[0],
                              instrD.sView.immHi[5:0], instrD.sView.immLo[4:1], 1'b0};
            IMM_J: extImmD = {{12{instrD.uView.imm20[19]}}, instrD.uView.imm20[7:0],
                              instrD.uView.imm20[8], instrD.uView.imm20[18:9], 1'b0};
            IMM_U: extImmD = {instrD.uView.imm20, 12'b0};
            default: extImmD = {{20{instrD.iView.imm12[11]}}, instrD.iView.imm12};
        endcase
    end

    regFile i_regFile (
        .clk(clk), .we(memWb.regWrite), .ra1(rs1D), .ra2(rs2D),
        .wa(memWb.rd), .wd(resultW), .rd1(rd1D), .rd2(rd2D)
    );

    always_ff @(posedge clk) begin
        if (rst || flushE)
            idEx <= '0;
        else
            idEx <= '{regWrite: ctrlD.regWrite, memWrite: ctrlD.memWrite,
                      aluSrc: ctrlD.aluSrc, aluOp: ctrlD.aluOp,
                      resultSel: ctrlD.resultSel, branch: ctrlD.branch,
                      jump: ctrlD.jump, pc: ifId.pc, pcPlus4: ifId.pcPlus4,
                      rd1: rd1D, rd2: rd2D, extImm: extImmD,
                      rs1: rs1D, rs2: rs2D, rd: rdD};
    end

    // execute
    assign srcAE      = fwdMux(forwardAE, idEx.rd1, resultW, exMem.aluResult, exMem.extImm);
    assign writeDataE = fwdMux(forwardBE, idEx.rd2, resultW, exMem.aluResult, exMem.extImm);
    assign srcBE      = idEx.aluSrc ? idEx.extImm : writeDataE;

    alu i_alu (
        .aluOp(idEx.aluOp), .a(srcAE), .b(srcBE),
        .result(aluResultE), .zero(zeroE), .neg(negE)
    );

    assign pcTargetE = (idEx.jump == JMP_JALR) ? {aluResultE[31:1], 1'b0}
                                               : idEx.pc + idEx.extImm;

    always_comb begin
        case (idEx.branch)
            BR_EQ:   takenE = zeroE;
            BR_NE:   takenE = !zeroE;
            BR_LT:   takenE = negE;
            default: takenE = 1'b0;
        endcase
    end
    assign pcSrcE = takenE || (idEx.jump != JMP_NONE);

    always_ff @(posedge clk) begin
        if (rst)
            exMem <= '0;
        else
            exMem <= '{regWrite: idEx.regWrite, memWrite: idEx.memWrite,
                       resultSel: idEx.resultSel, aluResult: aluResultE,
                       writeData: writeDataE, pcPlus4: idEx.pcPlus4,
                       extImm: idEx.extImm, rd: idEx.rd};
    end

    // memory
    assign dmemAddr  = exMem.aluResult;
    assign dmemWdata = exMem.writeData;
    assign dmemWe    = exMem.memWrite;

    always_ff @(posedge clk) begin
        if (rst)
            memWb <= '0;
        else
            memWb <= '{regWrite: exMem.regWrite, resultSel: exMem.resultSel,
                       aluResult: exMem.aluResult, readData: dmemRdata,
                       pcPlus4: exMem.pcPlus4, extImm: exMem.extImm, rd: exMem.rd};
    end

    // writeback
    always_comb begin
        case (memWb.resultSel)
            RES_MEM: resultW = memWb.readData;
            RES_PC4: resultW = memWb.pcPlus4;
            RES_IMM: resultW = memWb.extImm;
            default: resultW = memWb.aluResult;
        endcase
    end

    hazardUnit i_hazardUnit (
        .rs1D(rs1D), .rs2D(rs2D), .rs1E(idEx.rs1), .rs2E(idEx.rs2),
        .rdE(idEx.rd), .rdM(exMem.rd), .rdW(memWb.rd),
        .regWriteM(exMem.regWrite), .regWriteW(memWb.regWrite),
        .loadE(idEx.resultSel == RES_MEM), .immSelM(exMem.resultSel == RES_IMM),
        .pcSrcE(pcSrcE), .stallF(stallF), .stallD(stallD),
        .flushD(flushD), .flushE(flushE),
        .forwardAE(forwardAE), .forwardBE(forwardBE)
    );

endmodule

// File: riscvCore.sv
`timescale 1ns/100ps

module riscvCore #(
    parameter logic [31:0] resetPc = 32'h0
) (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] imemAddr,
    input  logic [31:0] imemData,
    output logic [31:0] dmemAddr,
    output logic [31:0] dmemWdata,
    output logic        dmemWe,
    input  logic [31:0] dmemRdata
);
    import riscvPkg::*;

    ctrlSig_s   ctrlD;
    opcode_e    op;
    logic [2:0] func3;
    logic       func7;

    controlUnit i_controlUnit (
        .op(op),
        .func3(func3),
        .func7(func7),
        .ctrl(ctrlD)
    );

    riscvDatapath #(
        .resetPc(resetPc)
    ) i_riscvDatapath (
        .clk(clk),
        .rst(rst),
        .ctrlD(ctrlD),
        .op(op),
        .func3(func3),
        .func7(func7),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .dmemAddr(dmemAddr),
        .dmemWdata(dmemWdata),
        .dmemWe(dmemWe),
        .dmemRdata(dmemRdata)
    );

endmodule

// File: tb_riscvCore.sv
`timescale 1ns/100ps

module tb_riscvCore;

    localparam logic [31:0] resetPc = 32'h0;
    localparam logic [31:0] markerAddr = 32'h3fc;
    localparam int timeoutCycles = 300;
    localparam int opImm = 'h13;
    localparam int opLoad = 'h03;
    localparam int opJalr = 'h67;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [31:0] imemAddr;
    logic [31:0] imemData;
    logic [31:0] dmemAddr;
    logic [31:0] dmemWdata;
    logic [31:0] dmemRdata;
    logic        dmemWe;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] expAddr [16];
    logic [31:0] expData [16];

    int    expCount = 0;
    int    storeIdx = 0;
    int    sinceRst = 0;
    int    resetEdges = 0;
    int    progLen = 0;
    int    errCount = 0;
    int    errAtStart = 0;
    int    passCount = 0;
    int    failCount = 0;
    int    testNum = 0;
    string testName = "";

    riscvCore #(.resetPc(resetPc)) i_riscvCore (
        .clk(clk), .rst(rst), .imemAddr(imemAddr), .imemData(imemData),
        .dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemWe(dmemWe), .dmemRdata(dmemRdata)
    );

    always #2 clk = ~clk;

    // single-cycle memories
    assign imemData  = imem[imemAddr[9:2]];
    assign dmemRdata = dmem[dmemAddr[9:2]];

    always @(posedge clk) begin
        if (dmemWe)
            dmem[dmemAddr[9:2]] <= dmemWdata;
    end

    always @(posedge clk) begin
        if (rst) begin
            storeIdx <= 0;
            sinceRst <= 0;
            resetEdges <= resetEdges + 1;
        end else begin
            sinceRst <= sinceRst + 1;
            if (dmemWe)
                storeIdx <= storeIdx + 1;
        end
    end

    // stores must come in program order
    storeExtra: assert property (@(posedge clk) disable iff (rst) dmemWe |-> storeIdx < expCount)
        else begin
            errCount++;
            $display("unexpected extra store to address %h in test %s",
                     $sampled(dmemAddr), testName);
        end
    storeAddr: assert property (@(posedge clk) disable iff (rst)
                                dmemWe |-> dmemAddr == expAddr[storeIdx])
        else begin
            errCount++;
            $display("FAIL dmemAddr got %h expected %h", $sampled(dmemAddr),
                     $sampled(expAddr[storeIdx]));
        end
    storeData: assert property (@(posedge clk) disable iff (rst)
                                dmemWe |-> dmemWdata == expData[storeIdx])
        else begin
            errCount++;
            $display("FAIL dmemWdata got %h expected %h", $sampled(dmemWdata),
                     $sampled(expData[storeIdx]));
        end

    // a store needs at least three cycles to reach the memory stage
    resetQuiet: assert property (@(posedge clk)
                                 ((rst && resetEdges != 0) || (!rst && sinceRst < 3)) |-> !dmemWe)
        else begin
            errCount++;
            $display("FAIL dmemWe got %h expected 0", $sampled(dmemWe));
        end
    resetFetch: assert property (@(posedge clk) (!rst && sinceRst == 0) |-> imemAddr == resetPc)
        else begin
            errCount++;
            $display("FAIL imemAddr got %h expected %h", $sampled(imemAddr), resetPc);
        end

    function automatic logic [31:0] rType(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] iType(input int imm, input int rs1, input int f3,
                                          input int rd, input int opc);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'(opc)};
    endfunction

    function automatic logic [31:0] sType(input int imm, input int rs2, input int rs1);
        logic [11:0] i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] bType(input int imm, input int rs2, input int rs1,
                                          input int f3);
        logic [12:0] i = 13'(imm);
        return {i[12], i[10:5], 5'(rs2), 5'(rs1), 3'(f3), i[4:1], i[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jType(input int imm, input int rd);
        logic [20:0] i = 21'(imm);
        return {i[20], i[10:1], i[11], i[19:12], 5'(rd), 7'b1101111};
    endfunction

    function automatic logic [31:0] uType(input int imm20, input int rd);
        return {20'(imm20), 5'(rd), 7'b0110111};
    endfunction

    function automatic bit isTaken(input int f3, input logic [31:0] a, input logic [31:0] b);
        case (f3)
            0:       return a == b;
            1:       return a != b;
            default: return $signed(a) < $signed(b);
        endcase
    endfunction

    function automatic int rand12();
        return int'($urandom % 4096) - 2048;
    endfunction

    function automatic logic [31:0] nextPc();
        return resetPc + 32'(4 * progLen);
    endfunction

    task automatic placeInstr(input logic [31:0] word);
        imem[progLen + int'(resetPc[9:2])] = word;
        progLen++;
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
        expAddr[expCount] = addr;
        expData[expCount] = data;
        expCount++;
    endtask

    task automatic beginTest(input string name);
        @(posedge clk);
        rst <= 1'b1;
        testNum++;
        testName = name;
        errAtStart = errCount;
        progLen = 0;
        expCount = 0;
        // nop fill and an address-dependent data pattern
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h00000013;
            dmem[i] <= 32'(i) * 32'h9e3779b1 ^ 32'h5bd1e995;
        end
    endtask

    task automatic endTest();
        bit found;
        found = 1'b0;
        placeInstr(iType(int'(markerAddr[11:0]), 0, 0, 31, opImm));
        placeInstr(iType(testNum, 0, 0, 30, opImm));
        placeInstr(sType(0, 30, 31));
        expectStore(markerAddr, 32'(testNum));
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        for (int cyc = 0; cyc < timeoutCycles && !found; cyc++) begin
            @(negedge clk);
            found = dmemWe && dmemAddr == markerAddr;
        end
        if (!found) begin
            failCount++;
            $display("timeout: test %s never reached its marker store", testName);
        end else begin
            @(posedge clk);
            @(negedge clk);
            storeCount: assert (storeIdx == expCount)
                else begin
                    errCount++;
                    $display("test %s made %0d stores instead of %0d", testName, storeIdx, expCount);
                end
            if (errCount == errAtStart) begin
                passCount++;
                $display("test %0d %s passed", testNum, testName);
            end else begin
                failCount++;
                $display("test %0d %s failed with %0d errors", testNum, testName,
                         errCount - errAtStart);
            end
        end
    endtask

    task automatic forwardingTest();
        int          immA;
        int          immB;
        logic [31:0] va;
        logic [31:0] vb;
        logic [31:0] v3;
        logic [31:0] v4;
        logic [31:0] v5;
        logic [31:0] v6;
        beginTest("back-to-back forwarding");
        immA = rand12();
        immB = rand12();
        va = 32'(immA);
        vb = 32'(immB);
        v3 = va + vb;
        v4 = v3 - va;
        v5 = v4 & v3;
        v6 = v5 | v4;
        placeInstr(iType(immA, 0, 0, 1, opImm));
        placeInstr(iType(immB, 0, 0, 2, opImm));
        placeInstr(rType('h00, 2, 1, 0, 3));
        placeInstr(rType('h20, 1, 3, 0, 4));
        placeInstr(rType('h00, 3, 4, 7, 5));
        placeInstr(rType('h00, 4, 5, 6, 6));
        placeInstr(rType('h00, 1, 6, 2, 7));
        // store data straight from the memory stage
        placeInstr(sType('h110, 7, 0));
        expectStore(32'h110, ($signed(v6) < $signed(va)) ? 32'd1 : 32'd0);
        for (int k = 0; k < 4; k++)
            placeInstr(sType('h100 + 4 * k, 3 + k, 0));
        expectStore(32'h100, v3);
        expectStore(32'h104, v4);
        expectStore(32'h108, v5);
        expectStore(32'h10c, v6);
        endTest();
    endtask

    task automatic luiTest();
        int upper;
        int addend;
        beginTest("lui forwarding");
        upper = int'($urandom % 32'h100000);
        addend = rand12();
        placeInstr(uType(upper, 9));
        placeInstr(iType(addend, 9, 0, 10, opImm));
        placeInstr(sType('h120, 10, 0));
        placeInstr(uType(upper, 11));
        placeInstr(sType('h124, 11, 0));
        expectStore(32'h120, {20'(upper), 12'h0} + 32'(addend));
        expectStore(32'h124, {20'(upper), 12'h0});
        endTest();
    endtask

    task automatic loadUseTest();
        logic [31:0] value;
        logic [31:0] rounded;
        beginTest("load-use stall");
        value = $urandom;
        // lui part rounded so the signed low part lands on the value
        rounded = value + 32'h800;
        placeInstr(uType(int'(rounded[31:12]), 1));
        placeInstr(iType(int'(value[11:0]), 1, 0, 1, opImm));
        placeInstr(sType('h140, 1, 0));
        placeInstr(iType('h140, 0, 2, 2, opLoad));
        placeInstr(rType('h00, 2, 2, 0, 3));
        placeInstr(sType('h144, 3, 0));
        expectStore(32'h140, value);
        expectStore(32'h144, value + value);
        endTest();
    endtask

    task automatic branchCase(input int idx, input int f3, input int rsA, input int rsB,
                              input bit taken, inout int sum);
        placeInstr(bType(12, rsB, rsA, f3));
        placeInstr(iType(1 << idx, 20, 0, 20, opImm));
        placeInstr(iType(1 << (idx + 5), 20, 0, 20, opImm));
        if (!taken)
            sum += (1 << idx) + (1 << (idx + 5));
    endtask

    task automatic branchTest();
        int          ia;
        int          ib;
        int          sum;
        logic [31:0] va;
        logic [31:0] vb;
        beginTest("branch flush");
        sum = 0;
        ia = rand12();
        ib = rand12();
        if (ib == ia)
            ib = ia ^ 1;
        va = 32'(ia);
        vb = 32'(ib);
        placeInstr(iType(0, 0, 0, 20, opImm));
        placeInstr(iType(ia, 0, 0, 1, opImm));
        placeInstr(iType(ib, 0, 0, 2, opImm));
        branchCase(0, 0, 1, 1, isTaken(0, va, va), sum);
        branchCase(1, 0, 1, 2, isTaken(0, va, vb), sum);
        branchCase(2, 1, 1, 2, isTaken(1, va, vb), sum);
        branchCase(3, 1, 2, 2, isTaken(1, vb, vb), sum);
        branchCase(4, 4, 1, 2, isTaken(4, va, vb), sum);
        branchCase(5, 4, 2, 1, isTaken(4, vb, va), sum);
        placeInstr(sType('h160, 20, 0));
        expectStore(32'h160, 32'(sum));
        endTest();
    endtask

    task automatic jumpTest();
        logic [31:0] jalPc;
        logic [31:0] jalrPc;
        beginTest("jumps");
        placeInstr(iType('h55, 0, 0, 6, opImm));
        jalPc = nextPc();
        placeInstr(jType(12, 1));
        placeInstr(iType(1, 0, 0, 6, opImm));
        placeInstr(iType(2, 0, 0, 6, opImm));
        placeInstr(sType('h180, 1, 0));
        jalrPc = nextPc() + 32'd4;
        // jalr lands three words past itself via an offset of 8
        placeInstr(iType(int'(jalrPc + 32'd12 - 32'd8), 0, 0, 7, opImm));
        placeInstr(iType(8, 7, 0, 8, opJalr));
        placeInstr(iType(3, 0, 0, 6, opImm));
        placeInstr(iType(4, 0, 0, 6, opImm));
        placeInstr(sType('h184, 8, 0));
        placeInstr(sType('h188, 6, 0));
        expectStore(32'h180, jalPc + 32'd4);
        expectStore(32'h184, jalrPc + 32'd4);
        expectStore(32'h188, 32'h55);
        endTest();
    endtask

    task automatic resetTest();
        beginTest("reset state");
        // earliest possible store right after reset
        placeInstr(sType('h10, 0, 0));
        expectStore(32'h10, 32'h0);
        endTest();
    endtask

    initial begin
        void'($urandom(32'hd5fe));
        forwardingTest();
        luiTest();
        loadUseTest();
        branchTest();
        jumpTest();
        resetTest();
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 testNum, passCount, failCount, errCount);
        if (failCount == 0 && errCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
riscvPkg.sv
alu.sv
regFile.sv
hazardUnit.sv
controlUnit.sv
riscvDatapath.sv
riscvCore.sv
tb_riscvCore.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_riscvCore -f verilog.f -o simv
./obj_dir/simv | tee sim.log

grep -q "Simulation completed successfully" sim.log
